/* flist.f */
source/soc_pkg.sv
source/obi_bus_if.sv
source/bus_decoder.sv
source/sram_bank.sv
source/soc_ctrl_regs.sv
source/gpio_regs.sv
source/soc_domain.sv
verif/soc_domain_tb.sv

/* run.sh */
#!/bin/sh
# Build the SoC domain testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f flist.f \
  --top-module soc_domain_tb -o soc_domain_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/soc_domain_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1

/* source/bus_decoder.sv */
// Routes upstream OBI accesses to SRAM, SoC control or GPIO and answers unmapped ones with err
`timescale 1ns/1ps

module bus_decoder (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr up_bus,
  obi_bus_if.mgr sram_bus,
  obi_bus_if.mgr ctrl_bus,
  obi_bus_if.mgr gpio_bus
);

  logic       sram_hit;
  logic       ctrl_hit;
  logic       gpio_hit;
  logic       miss;
  logic       accept;
  // One bit per target: 0 SRAM, 1 SoC control, 2 GPIO
  logic [2:0] sel_q;
  logic       err_q;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign sram_hit = up_bus.addr[soc_pkg::AddrWidth-1:soc_pkg::SramWindowBits] ==
                    soc_pkg::SramBaseAddr[soc_pkg::AddrWidth-1:soc_pkg::SramWindowBits];
  assign ctrl_hit = up_bus.addr[soc_pkg::AddrWidth-1:soc_pkg::PeriphWindowBits] ==
                    soc_pkg::SocCtrlBaseAddr[soc_pkg::AddrWidth-1:soc_pkg::PeriphWindowBits];
  assign gpio_hit = up_bus.addr[soc_pkg::AddrWidth-1:soc_pkg::PeriphWindowBits] ==
                    soc_pkg::GpioBaseAddr[soc_pkg::AddrWidth-1:soc_pkg::PeriphWindowBits];
  assign miss     = ~(sram_hit | ctrl_hit | gpio_hit);

  // ------------------------------
  // Request routing
  // ------------------------------
  // Only the matching target sees req, the rest of the request is shared
  assign sram_bus.req   = up_bus.req & sram_hit;
  assign sram_bus.addr  = up_bus.addr;
  assign sram_bus.we    = up_bus.we;
  assign sram_bus.be    = up_bus.be;
  assign sram_bus.wdata = up_bus.wdata;

  assign ctrl_bus.req   = up_bus.req & ctrl_hit;
  assign ctrl_bus.addr  = up_bus.addr;
  assign ctrl_bus.we    = up_bus.we;
  assign ctrl_bus.be    = up_bus.be;
  assign ctrl_bus.wdata = up_bus.wdata;

  assign gpio_bus.req   = up_bus.req & gpio_hit;
  assign gpio_bus.addr  = up_bus.addr;
  assign gpio_bus.we    = up_bus.we;
  assign gpio_bus.be    = up_bus.be;
  assign gpio_bus.wdata = up_bus.wdata;

  // Error responder grants immediately
  assign up_bus.gnt = (sram_hit & sram_bus.gnt) | (ctrl_hit & ctrl_bus.gnt) |
                      (gpio_hit & gpio_bus.gnt) | (miss & up_bus.req);

  assign accept = up_bus.req & up_bus.gnt;

  // Remember who owns the response of this cycle's access
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= '0;
      err_q <= 1'b0;
    end else begin
      sel_q <= accept ? {gpio_hit, ctrl_hit, sram_hit} : 3'b000;
      err_q <= accept & miss;
    end
  end

  // ------------------------------
  // Response steering
  // ------------------------------
  always_comb begin
    up_bus.rvalid = 1'b0;
    up_bus.rdata  = '0;
    up_bus.err    = 1'b0;
    if (err_q) begin
      up_bus.rvalid = 1'b1;
      up_bus.rdata  = soc_pkg::ErrRspData;
      up_bus.err    = 1'b1;
    end else if (sel_q[0]) begin
      up_bus.rvalid = sram_bus.rvalid;
      up_bus.rdata  = sram_bus.rdata;
      up_bus.err    = sram_bus.err;
    end else if (sel_q[1]) begin
      up_bus.rvalid = ctrl_bus.rvalid;
      up_bus.rdata  = ctrl_bus.rdata;
      up_bus.err    = ctrl_bus.err;
    end else if (sel_q[2]) begin
      up_bus.rvalid = gpio_bus.rvalid;
      up_bus.rdata  = gpio_bus.rdata;
      up_bus.err    = gpio_bus.err;
    end
  end

endmodule

/* source/gpio_regs.sv */
// GPIO block with direction and output registers, synchronized inputs and rising-edge interrupts
`timescale 1ns/1ps

module gpio_regs #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  obi_bus_if.sbr               bus,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o,
  output logic [GpioCount-1:0] gpio_in_sync_o,
  output logic                 gpio_irq_o
);

  logic [soc_pkg::PeriphWindowBits-1:0] offs;
  logic                                 wr_en;
  logic [GpioCount-1:0] dir_q;
  logic [GpioCount-1:0] out_q;
  logic [GpioCount-1:0] irq_en_q;
  logic [GpioCount-1:0] irq_status_q;
  logic [GpioCount-1:0] in_meta_q;
  logic [GpioCount-1:0] in_sync_q;
  logic [GpioCount-1:0] in_prev_q;
  logic [GpioCount-1:0] rise;
  logic [GpioCount-1:0] status_clr;
  logic [soc_pkg::DataWidth-1:0] rdata_d;
  logic [soc_pkg::DataWidth-1:0] rdata_q;
  logic                          rvalid_q;

  assign offs    = bus.addr[soc_pkg::PeriphWindowBits-1:0];
  assign wr_en   = bus.req & bus.we;
  assign bus.gnt = bus.req;

  // ------------------------------
  // Input sync and edge detect
  // ------------------------------
  assign rise = in_sync_q & ~in_prev_q & irq_en_q;

  // Write-one-to-clear, a fresh edge wins over the clear
  assign status_clr = (wr_en && offs == soc_pkg::GpioIrqStatusOffs) ?
                      bus.wdata[GpioCount-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_meta_q    <= '0;
      in_sync_q    <= '0;
      in_prev_q    <= '0;
      irq_status_q <= '0;
    end else begin
      in_meta_q    <= gpio_i;
      in_sync_q    <= in_meta_q;
      in_prev_q    <= in_sync_q;
      irq_status_q <= (irq_status_q & ~status_clr) | rise;
    end
  end

  // ------------------------------
  // Control registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      if (wr_en) begin
        case (offs)
          soc_pkg::GpioDirOffs:   dir_q    <= bus.wdata[GpioCount-1:0];
          soc_pkg::GpioOutOffs:   out_q    <= bus.wdata[GpioCount-1:0];
          soc_pkg::GpioIrqEnOffs: irq_en_q <= bus.wdata[GpioCount-1:0];
          default: ;
        endcase
      end
    end
  end

  // Readback, zero-extended to the bus width
  always_comb begin
    rdata_d = '0;
    case (offs)
      soc_pkg::GpioDirOffs:       rdata_d[GpioCount-1:0] = dir_q;
      soc_pkg::GpioInOffs:        rdata_d[GpioCount-1:0] = in_sync_q;
      soc_pkg::GpioOutOffs:       rdata_d[GpioCount-1:0] = out_q;
      soc_pkg::GpioIrqEnOffs:     rdata_d[GpioCount-1:0] = irq_en_q;
      soc_pkg::GpioIrqStatusOffs: rdata_d[GpioCount-1:0] = irq_status_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = in_sync_q;
  assign gpio_irq_o     = |irq_status_q;

endmodule

/* source/obi_bus_if.sv */
// Simplified OBI request/response bus, instantiated per link between decoder and subordinates
`timescale 1ns/1ps

interface obi_bus_if;

  // Request channel
  logic                           req;
  logic [soc_pkg::AddrWidth-1:0]  addr;
  logic                           we;
  logic [soc_pkg::BeWidth-1:0]    be;
  logic [soc_pkg::DataWidth-1:0]  wdata;

  // Grant and response channel
  logic                           gnt;
  logic                           rvalid;
  logic [soc_pkg::DataWidth-1:0]  rdata;
  logic                           err;

  modport mgr (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport sbr (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

/* source/soc_ctrl_regs.sv */
// SoC control registers holding the boot address and the software fetch enable
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          fetch_en_i,
  obi_bus_if.sbr                        bus,
  output logic                          fetch_enable_o,
  output logic [soc_pkg::AddrWidth-1:0] boot_addr_o
);

  logic [soc_pkg::PeriphWindowBits-1:0] offs;
  logic [soc_pkg::AddrWidth-1:0]        boot_addr_q;
  logic                                 fetch_en_q;
  logic [soc_pkg::DataWidth-1:0]        rdata_d;
  logic [soc_pkg::DataWidth-1:0]        rdata_q;
  logic                                 rvalid_q;

  assign offs    = bus.addr[soc_pkg::PeriphWindowBits-1:0];
  assign bus.gnt = bus.req;

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_addr_q <= soc_pkg::SramBaseAddr;
      fetch_en_q  <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
      // Whole word written, be is ignored
      if (bus.req && bus.we) begin
        case (offs)
          soc_pkg::BootAddrOffs: boot_addr_q <= bus.wdata;
          soc_pkg::FetchEnOffs:  fetch_en_q  <= bus.wdata[0];
          default: ;
        endcase
      end
    end
  end

  // Readback, unknown offsets read as zero
  always_comb begin
    rdata_d = '0;
    case (offs)
      soc_pkg::BootAddrOffs: rdata_d = boot_addr_q;
      soc_pkg::FetchEnOffs:  rdata_d[0] = fetch_en_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

  // Either the pin or software may start the core
  assign fetch_enable_o = fetch_en_q | fetch_en_i;
  assign boot_addr_o    = boot_addr_q;

endmodule

/* source/soc_domain.sv */
// SoC domain top level joining the external bus port to the decoder, SRAM and peripherals
`timescale 1ns/1ps

module soc_domain #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          fetch_en_i,

  // External manager port
  input  logic                          bus_req_i,
  input  logic [soc_pkg::AddrWidth-1:0] bus_addr_i,
  input  logic                          bus_we_i,
  input  logic [soc_pkg::BeWidth-1:0]   bus_be_i,
  input  logic [soc_pkg::DataWidth-1:0] bus_wdata_i,
  output logic                          bus_gnt_o,
  output logic                          bus_rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] bus_rdata_o,
  output logic                          bus_err_o,

  // GPIO pins
  input  logic [GpioCount-1:0]          gpio_i,
  output logic [GpioCount-1:0]          gpio_o,
  output logic [GpioCount-1:0]          gpio_out_en_o,
  output logic [GpioCount-1:0]          gpio_in_sync_o,
  output logic                          gpio_irq_o,

  // Core boot control
  output logic                          fetch_enable_o,
  output logic [soc_pkg::AddrWidth-1:0] boot_addr_o
);

  // ------------------------------
  // Internal buses
  // ------------------------------
  obi_bus_if up_bus ();
  obi_bus_if sram_bus ();
  obi_bus_if ctrl_bus ();
  obi_bus_if gpio_bus ();

  assign up_bus.req   = bus_req_i;
  assign up_bus.addr  = bus_addr_i;
  assign up_bus.we    = bus_we_i;
  assign up_bus.be    = bus_be_i;
  assign up_bus.wdata = bus_wdata_i;

  assign bus_gnt_o    = up_bus.gnt;
  assign bus_rvalid_o = up_bus.rvalid;
  assign bus_rdata_o  = up_bus.rdata;
  assign bus_err_o    = up_bus.err;

  // ------------------------------
  // Fabric and subordinates
  // ------------------------------
  bus_decoder i_bus_decoder (
    .clk_i    ( clk_i    ),
    .rst_n_i  ( rst_n_i  ),
    .up_bus   ( up_bus   ),
    .sram_bus ( sram_bus ),
    .ctrl_bus ( ctrl_bus ),
    .gpio_bus ( gpio_bus )
  );

  sram_bank i_sram_bank (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .bus     ( sram_bus )
  );

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_en_i     ( fetch_en_i     ),
    .bus            ( ctrl_bus       ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  gpio_regs #(
    .GpioCount ( GpioCount )
  ) i_gpio_regs (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .bus            ( gpio_bus       ),
    .gpio_i         ( gpio_i         ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o ),
    .gpio_irq_o     ( gpio_irq_o     )
  );

endmodule

/* source/soc_pkg.sv */
// Address map, bus widths and register offsets shared by every block of the SoC domain
package soc_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Byte lane bits below the word address
  localparam int unsigned ByteOffsBits = $clog2(BeWidth);

  // ------------------------------
  // Address map
  // ------------------------------
  localparam logic [AddrWidth-1:0] SramBaseAddr    = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] SocCtrlBaseAddr = 32'h0300_0000;
  localparam logic [AddrWidth-1:0] GpioBaseAddr    = 32'h0300_1000;

  // 512 words gives a 2 KiB window
  localparam int unsigned SramNumWords   = 512;
  localparam int unsigned SramAddrBits   = $clog2(SramNumWords);
  localparam int unsigned SramWindowBits = SramAddrBits + ByteOffsBits;

  // Each peripheral owns a 4 KiB window
  localparam int unsigned PeriphWindowBits = 12;

  // Returned on any access outside the map
  localparam logic [DataWidth-1:0] ErrRspData = 32'hBADCAB1E;

  // ------------------------------
  // SoC control register offsets
  // ------------------------------
  localparam logic [PeriphWindowBits-1:0] BootAddrOffs = 12'h000;
  localparam logic [PeriphWindowBits-1:0] FetchEnOffs  = 12'h004;

  // ------------------------------
  // GPIO register offsets
  // ------------------------------
  localparam logic [PeriphWindowBits-1:0] GpioDirOffs       = 12'h000;
  localparam logic [PeriphWindowBits-1:0] GpioInOffs        = 12'h004;
  localparam logic [PeriphWindowBits-1:0] GpioOutOffs       = 12'h008;
  localparam logic [PeriphWindowBits-1:0] GpioIrqEnOffs     = 12'h00C;
  localparam logic [PeriphWindowBits-1:0] GpioIrqStatusOffs = 12'h010;

endpackage

/* source/sram_bank.sv */
// Single-port word SRAM with byte enables, answering OBI accesses one cycle after the request
`timescale 1ns/1ps

module sram_bank (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr bus
);

  logic [soc_pkg::DataWidth-1:0]    mem_q [soc_pkg::SramNumWords];
  logic [soc_pkg::SramAddrBits-1:0] word_idx;
  logic [soc_pkg::DataWidth-1:0]    rdata_q;
  logic                             rvalid_q;

  // Word index within the 2 KiB window
  assign word_idx = bus.addr[soc_pkg::SramWindowBits-1:soc_pkg::ByteOffsBits];

  // No back-pressure
  assign bus.gnt = bus.req;

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int b = 0; b < soc_pkg::BeWidth; b++) begin
          if (bus.be[b]) begin
            mem_q[word_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  // ------------------------------
  // Response
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

/* verif/soc_domain_tb.sv */
// Directed testbench that drives the SoC domain top level and runs as the simulation top
`timescale 1ns/1ps

module soc_domain_tb;

  localparam logic [31:0] SramBase = 32'h1000_0000;
  localparam logic [31:0] CtrlBase = 32'h0300_0000;
  localparam logic [31:0] GpioBase = 32'h0300_1000;
  localparam logic [31:0] NoTarget = 32'h2000_0000;
  localparam int          Timeout  = 16;

  logic        clk_i;
  logic        rst_n_i;
  logic        fetch_en_i;
  logic        bus_req_i;
  logic [31:0] bus_addr_i;
  logic        bus_we_i;
  logic [3:0]  bus_be_i;
  logic [31:0] bus_wdata_i;
  logic        bus_gnt_o;
  logic        bus_rvalid_o;
  logic [31:0] bus_rdata_o;
  logic        bus_err_o;
  logic [15:0] gpio_i;
  logic [15:0] gpio_o;
  logic [15:0] gpio_out_en_o;
  logic [15:0] gpio_in_sync_o;
  logic        gpio_irq_o;
  logic        fetch_enable_o;
  logic [31:0] boot_addr_o;
  int          errors = 0;
  int          tests_run = 0;

  soc_domain #(.GpioCount(16)) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests_run++;
    $display("%-12s done, %0d errors", name, errors - errs_at_start);
  endtask

  // ------------------------------
  // Single bus access
  // ------------------------------
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    @(negedge clk_i);
    bus_req_i   = 1'b1;
    bus_addr_i  = addr;
    bus_we_i    = wr;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    @(posedge clk_i);
    if (!bus_gnt_o) begin
      $display("No grant for the access to %h", addr);
      errors++;
    end
    @(negedge clk_i);
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
    waits     = 0;
    while (!bus_rvalid_o && waits < Timeout) begin
      @(negedge clk_i);
      waits++;
    end
    if (!bus_rvalid_o) begin
      $display("Timed out waiting for the response to %h", addr);
      errors++;
      rdata = 'x;
      err   = 1'bx;
    end else begin
      rdata = bus_rdata_o;
      err   = bus_err_o;
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_reset();
    logic [31:0] rd;
    logic        er;
    int          e0;
    e0 = errors;
    check_val("bus_rvalid_o", 32'(bus_rvalid_o), 32'h0);
    check_val("gpio_o", 32'(gpio_o), 32'h0);
    check_val("gpio_out_en_o", 32'(gpio_out_en_o), 32'h0);
    check_val("gpio_irq_o", 32'(gpio_irq_o), 32'h0);
    check_val("boot_addr_o", boot_addr_o, SramBase);
    bus_access(1'b0, CtrlBase, 4'h0, 32'h0, rd, er);
    check_val("bus_rdata_o", rd, SramBase);
    check_val("bus_err_o", 32'(er), 32'h0);
    // Fetch enable register is clear, so the pin passes straight through
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_i);
      fetch_en_i = (i % 2 == 0);
      @(posedge clk_i);
      check_val("fetch_enable_o", 32'(fetch_enable_o), 32'(fetch_en_i));
    end
    end_test("reset", e0);
  endtask

  task automatic test_sram();
    logic [31:0] addrs [8];
    logic [31:0] exp   [8];
    logic [31:0] word;
    logic [31:0] rd;
    logic        er;
    int          e0;
    int          cyc;
    int          got;
    e0 = errors;
    // One word per 64-word slice keeps the addresses distinct
    for (int k = 0; k < 8; k++) begin
      addrs[k] = SramBase + (k * 64 + ($urandom % 64)) * 4;
      exp[k]   = $urandom;
      bus_access(1'b1, addrs[k], 4'hF, exp[k], rd, er);
      check_val("bus_err_o", 32'(er), 32'h0);
    end
    word = $urandom;
    bus_access(1'b1, addrs[3], 4'b0101, word, rd, er);
    exp[3] = {exp[3][31:24], word[23:16], exp[3][15:8], word[7:0]};
    for (int k = 0; k < 8; k++) begin
      bus_access(1'b0, addrs[k], 4'h0, 32'h0, rd, er);
      check_val("bus_rdata_o", rd, exp[k]);
      check_val("bus_err_o", 32'(er), 32'h0);
    end
    // Back-to-back reads with response i due in cycle i + 1
    cyc = 0;
    got = 0;
    while (got < 8 && cyc < 8 + Timeout) begin
      @(negedge clk_i);
      if (bus_rvalid_o) begin
        if (cyc != got + 1) begin
          $display("Burst response %0d came in cycle %0d, not %0d", got, cyc, got + 1);
          errors++;
        end
        check_val("bus_rdata_o", bus_rdata_o, exp[got]);
        check_val("bus_err_o", 32'(bus_err_o), 32'h0);
        got++;
      end
      bus_req_i  = (cyc < 8);
      bus_addr_i = addrs[cyc % 8];
      @(posedge clk_i);
      if (cyc < 8 && !bus_gnt_o) begin
        $display("No grant for burst read %0d", cyc);
        errors++;
      end
      cyc++;
    end
    @(negedge clk_i);
    bus_req_i = 1'b0;
    if (got < 8) begin
      $display("Timed out with %0d of 8 burst responses", got);
      errors++;
    end
    end_test("sram", e0);
  endtask

  task automatic test_soc_ctrl();
    logic [31:0] word;
    logic [31:0] rd;
    logic        er;
    int          e0;
    e0   = errors;
    word = $urandom;
    bus_access(1'b1, CtrlBase, 4'hF, word, rd, er);
    check_val("boot_addr_o", boot_addr_o, word);
    bus_access(1'b0, CtrlBase, 4'h0, 32'h0, rd, er);
    check_val("bus_rdata_o", rd, word);
    @(negedge clk_i);
    fetch_en_i = 1'b0;
    bus_access(1'b1, CtrlBase + 32'h4, 4'hF, 32'h1, rd, er);
    check_val("fetch_enable_o", 32'(fetch_enable_o), 32'h1);
    bus_access(1'b0, CtrlBase + 32'h40, 4'h0, 32'h0, rd, er);
    check_val("bus_rdata_o", rd, 32'h0);
    check_val("bus_err_o", 32'(er), 32'h0);
    end_test("soc_ctrl", e0);
  endtask

  task automatic test_gpio_io();
    logic [15:0] dir;
    logic [15:0] outv;
    logic [15:0] pins;
    logic [31:0] rd;
    logic        er;
    int          e0;
    e0   = errors;
    dir  = 16'($urandom);
    outv = 16'($urandom);
    pins = 16'($urandom);
    bus_access(1'b1, GpioBase, 4'hF, 32'(dir), rd, er);
    bus_access(1'b1, GpioBase + 32'h8, 4'hF, 32'(outv), rd, er);
    check_val("gpio_out_en_o", 32'(gpio_out_en_o), 32'(dir));
    check_val("gpio_o", 32'(gpio_o), 32'(outv));
    @(negedge clk_i);
    gpio_i = pins;
    repeat (3) @(negedge clk_i);
    check_val("gpio_in_sync_o", 32'(gpio_in_sync_o), 32'(pins));
    bus_access(1'b0, GpioBase + 32'h4, 4'h0, 32'h0, rd, er);
    check_val("bus_rdata_o", rd, 32'(pins));
    end_test("gpio_io", e0);
  endtask

  task automatic test_gpio_irq();
    logic [15:0] en;
    logic [15:0] pins;
    logic [31:0] rd;
    logic        er;
    int          e0;
    e0   = errors;
    en   = 16'h00FF;
    pins = 16'h0F0F;
    // Settle all pins low so that no stale edge is pending
    @(negedge clk_i);
    gpio_i = 16'h0000;
    repeat (3) @(negedge clk_i);
    bus_access(1'b1, GpioBase + 32'hC, 4'hF, 32'(en), rd, er);
    @(negedge clk_i);
    gpio_i = pins;
    repeat (4) @(negedge clk_i);
    check_val("gpio_irq_o", 32'(gpio_irq_o), 32'h1);
    bus_access(1'b0, GpioBase + 32'h10, 4'h0, 32'h0, rd, er);
    check_val("bus_rdata_o", rd, 32'(pins & en));
    bus_access(1'b1, GpioBase + 32'h10, 4'hF, 32'(pins & en), rd, er);
    bus_access(1'b0, GpioBase + 32'h10, 4'h0, 32'h0, rd, er);
    check_val("bus_rdata_o", rd, 32'h0);
    check_val("gpio_irq_o", 32'(gpio_irq_o), 32'h0);
    end_test("gpio_irq", e0);
  endtask

  task automatic test_unmapped();
    logic [31:0] rd;
    logic        er;
    int          e0;
    e0 = errors;
    bus_access(1'b0, NoTarget, 4'h0, 32'h0, rd, er);
    check_val("bus_err_o", 32'(er), 32'h1);
    check_val("bus_rdata_o", rd, 32'hBADC_AB1E);
    bus_access(1'b1, NoTarget, 4'hF, 32'h1234_5678, rd, er);
    check_val("bus_err_o", 32'(er), 32'h1);
    bus_access(1'b0, SramBase, 4'h0, 32'h0, rd, er);
    check_val("bus_err_o", 32'(er), 32'h0);
    end_test("unmapped", e0);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    void'($urandom(32'h67c5_9903));
    rst_n_i     = 1'b0;
    fetch_en_i  = 1'b0;
    bus_req_i   = 1'b0;
    bus_addr_i  = 32'h0;
    bus_we_i    = 1'b0;
    bus_be_i    = 4'h0;
    bus_wdata_i = 32'h0;
    gpio_i      = 16'h0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    test_reset();
    test_sram();
    test_soc_ctrl();
    test_gpio_io();
    test_gpio_irq();
    test_unmapped();
    $display("Tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
